/* rtl/bus_int_addr_pkg.sv */
// Address map of the settings and readback buses
// Addresses are exact matches; no block decoding, no byte lanes
package bus_int_addr_pkg;

   //----------------------------------------------------------------------
   // Bus widths
   //----------------------------------------------------------------------
   localparam int SR_AWIDTH = 8;
   localparam int RB_AWIDTH = 8;
   // Shared by settings data and readback data
   localparam int DATA_W    = 32;

   //----------------------------------------------------------------------
   // Settings bus write addresses
   //----------------------------------------------------------------------
   localparam logic [SR_AWIDTH-1:0] SR_LEDS       = 0;
   localparam logic [SR_AWIDTH-1:0] SR_SW_RST     = 1;
   localparam logic [SR_AWIDTH-1:0] SR_CLOCK_CTRL = 2;
   // One rate-select register per SFP+ cage
   localparam logic [SR_AWIDTH-1:0] SR_SFPP_CTRL0 = 8;
   localparam logic [SR_AWIDTH-1:0] SR_SFPP_CTRL1 = 9;
   // Any write here clears the sticky FIFO word, data ignored
   localparam logic [SR_AWIDTH-1:0] SR_FIFOFLAGS  = 10;

   //----------------------------------------------------------------------
   // Readback addresses
   //----------------------------------------------------------------------
   localparam logic [RB_AWIDTH-1:0] RB_COUNTER      = 0;
   localparam logic [RB_AWIDTH-1:0] RB_CLK_STATUS   = 3;
   localparam logic [RB_AWIDTH-1:0] RB_COMPAT_NUM   = 6;
   // Strobed reads here clear that cage's change bits
   localparam logic [RB_AWIDTH-1:0] RB_SFPP_STATUS0 = 8;
   localparam logic [RB_AWIDTH-1:0] RB_SFPP_STATUS1 = 9;
   localparam logic [RB_AWIDTH-1:0] RB_FIFOFLAGS    = 10;

endpackage

/* rtl/bus_int_board_pkg.sv */
// Board-level facts: compat number, pin field widths, reset values
// Widths here must match the board pinout
package bus_int_board_pkg;

   // Compat number, major in the high half of the readback word
   localparam logic [15:0] COMPAT_MAJOR = 16'h0008;
   localparam logic [15:0] COMPAT_MINOR = 16'h0000;

   //----------------------------------------------------------------------
   // Board control and status field widths
   //----------------------------------------------------------------------
   localparam int LEDS_W         = 8;
   localparam int SW_RST_W       = 4;
   localparam int CLOCK_CTRL_W   = 7;
   localparam int CLOCK_STATUS_W = 5;

   // Bit 6 set, GPSDO on out of reset
   localparam logic [CLOCK_CTRL_W-1:0] CLOCK_CTRL_RESET = 7'h40;

   //----------------------------------------------------------------------
   // SFP+ cages and FIFO monitor
   //----------------------------------------------------------------------
   // Rate-select pins per cage, open drain
   localparam int SFPP_RS_W      = 2;
   // Three change bits above three level bits
   localparam int SFPP_STATUS_W  = 6;
   // External FIFO flags, active low
   localparam int NUM_FIFO_FLAGS = 4;

endpackage

/* rtl/setting_reg.sv */
// Single settings-bus register, takes the low WIDTH bits of the data word
// Exact address match; o_changed pulses even when the value is the same
`timescale 1ns/1ps

module setting_reg #(
   parameter logic [bus_int_addr_pkg::SR_AWIDTH-1:0] MY_ADDR = '0,
   parameter int WIDTH = 1,
   parameter logic [WIDTH-1:0] AT_RESET = '0
) (
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic                                   i_set_stb,
   input  logic [bus_int_addr_pkg::SR_AWIDTH-1:0] i_set_addr,
   input  logic [bus_int_addr_pkg::DATA_W-1:0]    i_set_data,
   output logic [WIDTH-1:0]                       o_value,
   output logic                                   o_changed
);

   // Write aimed at this register
   logic hit;

   assign hit = i_set_stb && (i_set_addr == MY_ADDR);

   always_ff @(posedge clk) begin
      if (reset) begin
         o_value   <= AT_RESET;
         o_changed <= 1'b0;
      end else begin
         // Pulse lines up with the new value
         o_changed <= hit;
         if (hit) begin
            o_value <= i_set_data[WIDTH-1:0];
         end
      end
   end

endmodule

/* rtl/sfpp_port.sv */
// One SFP+ cage: status pin sync, change latch, open-drain rate select
// Status pins are async, two flops only; no glitch filter
// o_rs needs an external pullup, pins float when their bit is clear
`timescale 1ns/1ps

module sfpp_port #(
   parameter logic [bus_int_addr_pkg::RB_AWIDTH-1:0] STATUS_ADDR =
      bus_int_addr_pkg::RB_SFPP_STATUS0,
   parameter logic [bus_int_addr_pkg::SR_AWIDTH-1:0] CTRL_ADDR =
      bus_int_addr_pkg::SR_SFPP_CTRL0
) (
   input  logic                                        clk,
   input  logic                                        reset,
   input  logic                                        i_set_stb,
   input  logic [bus_int_addr_pkg::SR_AWIDTH-1:0]      i_set_addr,
   input  logic [bus_int_addr_pkg::DATA_W-1:0]         i_set_data,
   input  logic [bus_int_addr_pkg::RB_AWIDTH-1:0]      i_rb_addr,
   input  logic                                        i_rb_rd_stb,
   input  logic                                        i_mod_abs,
   input  logic                                        i_tx_fault,
   input  logic                                        i_rx_los,
   output logic [bus_int_board_pkg::SFPP_STATUS_W-1:0] o_status,
   output wire  [bus_int_board_pkg::SFPP_RS_W-1:0]     o_rs
);

   import bus_int_board_pkg::*;

   // Half of the status word is levels, half is change bits
   localparam int NUM_PINS = SFPP_STATUS_W / 2;

   // Pin order ModAbs, TxFault, RxLOS from high to low
   logic [NUM_PINS-1:0]  pins;
   logic [NUM_PINS-1:0]  sync1;
   logic [NUM_PINS-1:0]  sync2;
   logic [NUM_PINS-1:0]  chgd;
   logic                 rd_clear;
   logic [SFPP_RS_W-1:0] rs_ctrl;

   assign pins     = {i_mod_abs, i_tx_fault, i_rx_los};
   // Strobed read of this cage's status word
   assign rd_clear = i_rb_rd_stb && (i_rb_addr == STATUS_ADDR);

   //----------------------------------------------------------------------
   // Status sync and change latch
   //----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         sync1 <= '0;
         sync2 <= '0;
      end else begin
         sync1 <= pins;
         sync2 <= sync1;
      end
   end

   // Stage mismatch means the pin moved; read clear has priority
   always_ff @(posedge clk) begin
      if (reset) begin
         chgd <= '0;
      end else if (rd_clear) begin
         chgd <= '0;
      end else begin
         chgd <= chgd | (sync1 ^ sync2);
      end
   end

   assign o_status = {chgd, sync2};

   //----------------------------------------------------------------------
   // Rate select
   //----------------------------------------------------------------------
   setting_reg #(
      .MY_ADDR  (CTRL_ADDR),
      .WIDTH    (SFPP_RS_W),
      .AT_RESET ({SFPP_RS_W{1'b0}})
   ) rs_reg (
      .clk        (clk),
      .reset      (reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_value    (rs_ctrl),
      .o_changed  ()
   );

   // Set bit pulls low, clear bit releases the pin
   for (genvar i = 0; i < SFPP_RS_W; i++) begin : g_rs
      assign o_rs[i] = rs_ctrl[i] ? 1'b0 : 1'bz;
   end

endmodule

/* rtl/fifo_flag_monitor.sv */
// Sticky capture of active-low FIFO flags; any write to CLEAR_ADDR clears
// A flag still low during the clear sets its bit again right after
`timescale 1ns/1ps

module fifo_flag_monitor #(
   parameter logic [bus_int_addr_pkg::SR_AWIDTH-1:0] CLEAR_ADDR =
      bus_int_addr_pkg::SR_FIFOFLAGS
) (
   input  logic                                         clk,
   input  logic                                         reset,
   input  logic                                         i_set_stb,
   input  logic [bus_int_addr_pkg::SR_AWIDTH-1:0]       i_set_addr,
   input  logic [bus_int_addr_pkg::DATA_W-1:0]          i_set_data,
   input  logic [bus_int_board_pkg::NUM_FIFO_FLAGS-1:0] i_fifo_flags,
   output logic [bus_int_addr_pkg::DATA_W-1:0]          o_flags
);

   import bus_int_addr_pkg::*;
   import bus_int_board_pkg::*;

   logic                      clear;
   logic [NUM_FIFO_FLAGS-1:0] sticky;

   // Only the write pulse matters, value is dropped
   setting_reg #(
      .MY_ADDR (CLEAR_ADDR),
      .WIDTH   (1)
   ) clear_reg (
      .clk        (clk),
      .reset      (reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_value    (),
      .o_changed  (clear)
   );

   // Clear wins over a flag low in the same cycle
   always_ff @(posedge clk) begin
      if (reset || clear) begin
         sticky <= '0;
      end else begin
         sticky <= sticky | ~i_fifo_flags;
      end
   end

   assign o_flags = {{(DATA_W - NUM_FIFO_FLAGS){1'b0}}, sticky};

endmodule

/* rtl/readback_ctrl.sv */
// Readback decode plus free-running cycle counter
// o_rb_data is combinational from i_rb_addr; unmapped addresses read 0
`timescale 1ns/1ps

module readback_ctrl (
   input  logic                                         clk,
   input  logic                                         reset,
   input  logic [bus_int_addr_pkg::RB_AWIDTH-1:0]       i_rb_addr,
   input  logic [bus_int_board_pkg::CLOCK_STATUS_W-1:0] i_clock_status,
   input  logic [bus_int_board_pkg::SFPP_STATUS_W-1:0]  i_sfpp0_status,
   input  logic [bus_int_board_pkg::SFPP_STATUS_W-1:0]  i_sfpp1_status,
   input  logic [bus_int_addr_pkg::DATA_W-1:0]          i_fifo_flags_word,
   output logic [bus_int_addr_pkg::DATA_W-1:0]          o_rb_data
);

   import bus_int_addr_pkg::*;
   import bus_int_board_pkg::*;

   // Wraps silently at 2^32
   logic [DATA_W-1:0] counter;

   //----------------------------------------------------------------------
   // Cycle counter
   //----------------------------------------------------------------------
   // Reads zero in the first cycle out of reset
   always_ff @(posedge clk) begin
      if (reset) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;
      end
   end

   //----------------------------------------------------------------------
   // Address decode
   //----------------------------------------------------------------------
   always_comb begin
      case (i_rb_addr)
         RB_COUNTER: begin
            o_rb_data = counter;
         end
         RB_CLK_STATUS: begin
            o_rb_data = DATA_W'(i_clock_status);
         end
         // Major in the high half
         RB_COMPAT_NUM: begin
            o_rb_data = DATA_W'({COMPAT_MAJOR, COMPAT_MINOR});
         end
         RB_SFPP_STATUS0: begin
            o_rb_data = DATA_W'(i_sfpp0_status);
         end
         RB_SFPP_STATUS1: begin
            o_rb_data = DATA_W'(i_sfpp1_status);
         end
         // Already zero-extended by the monitor
         RB_FIFOFLAGS: begin
            o_rb_data = i_fifo_flags_word;
         end
         default: begin
            o_rb_data = '0;
         end
      endcase
   end

endmodule

/* rtl/bus_int_top.sv */
// Board-control register block on a settings bus and a readback port
// Single clock domain; SFP+ status and FIFO flags are sampled as async pins
// Rate-select outputs are open drain and need board pullups
`timescale 1ns/1ps

module bus_int_top (
   input  logic                                         clk,
   input  logic                                         reset,
   // Settings bus, one-cycle strobe
   input  logic                                         i_set_stb,
   input  logic [bus_int_addr_pkg::SR_AWIDTH-1:0]       i_set_addr,
   input  logic [bus_int_addr_pkg::DATA_W-1:0]          i_set_data,
   // Readback port
   input  logic [bus_int_addr_pkg::RB_AWIDTH-1:0]       i_rb_addr,
   input  logic                                         i_rb_rd_stb,
   output logic [bus_int_addr_pkg::DATA_W-1:0]          o_rb_data,
   // Board clocking and control
   input  logic [bus_int_board_pkg::CLOCK_STATUS_W-1:0] i_clock_status,
   output logic [bus_int_board_pkg::CLOCK_CTRL_W-1:0]   o_clock_control,
   output logic [bus_int_board_pkg::LEDS_W-1:0]         o_leds,
   output logic [bus_int_board_pkg::SW_RST_W-1:0]       o_sw_rst,
   input  logic [bus_int_board_pkg::NUM_FIFO_FLAGS-1:0] i_fifo_flags,
   // SFP+ cage 0
   input  logic                                         i_sfpp0_mod_abs,
   input  logic                                         i_sfpp0_tx_fault,
   input  logic                                         i_sfpp0_rx_los,
   output wire  [bus_int_board_pkg::SFPP_RS_W-1:0]      o_sfpp0_rs,
   // SFP+ cage 1
   input  logic                                         i_sfpp1_mod_abs,
   input  logic                                         i_sfpp1_tx_fault,
   input  logic                                         i_sfpp1_rx_los,
   output wire  [bus_int_board_pkg::SFPP_RS_W-1:0]      o_sfpp1_rs
);

   import bus_int_addr_pkg::*;
   import bus_int_board_pkg::*;

   logic [SFPP_STATUS_W-1:0] sfpp0_status;
   logic [SFPP_STATUS_W-1:0] sfpp1_status;
   logic [DATA_W-1:0]        fifo_flags_word;

   //----------------------------------------------------------------------
   // Plain control registers
   //----------------------------------------------------------------------
   setting_reg #(
      .MY_ADDR (SR_LEDS),
      .WIDTH   (LEDS_W)
   ) leds_reg (
      .clk        (clk),
      .reset      (reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_value    (o_leds),
      .o_changed  ()
   );

   // Bit 0 PHY, bit 1 radio domain, bit 2 radio PLL, bit 3 spare
   setting_reg #(
      .MY_ADDR (SR_SW_RST),
      .WIDTH   (SW_RST_W)
   ) sw_rst_reg (
      .clk        (clk),
      .reset      (reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_value    (o_sw_rst),
      .o_changed  ()
   );

   // Comes out of reset with the GPSDO enabled
   setting_reg #(
      .MY_ADDR  (SR_CLOCK_CTRL),
      .WIDTH    (CLOCK_CTRL_W),
      .AT_RESET (CLOCK_CTRL_RESET)
   ) clock_ctrl_reg (
      .clk        (clk),
      .reset      (reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_value    (o_clock_control),
      .o_changed  ()
   );

   //----------------------------------------------------------------------
   // SFP+ cages
   //----------------------------------------------------------------------
   sfpp_port #(
      .STATUS_ADDR (RB_SFPP_STATUS0),
      .CTRL_ADDR   (SR_SFPP_CTRL0)
   ) sfpp0 (
      .clk         (clk),
      .reset       (reset),
      .i_set_stb   (i_set_stb),
      .i_set_addr  (i_set_addr),
      .i_set_data  (i_set_data),
      .i_rb_addr   (i_rb_addr),
      .i_rb_rd_stb (i_rb_rd_stb),
      .i_mod_abs   (i_sfpp0_mod_abs),
      .i_tx_fault  (i_sfpp0_tx_fault),
      .i_rx_los    (i_sfpp0_rx_los),
      .o_status    (sfpp0_status),
      .o_rs        (o_sfpp0_rs)
   );

   sfpp_port #(
      .STATUS_ADDR (RB_SFPP_STATUS1),
      .CTRL_ADDR   (SR_SFPP_CTRL1)
   ) sfpp1 (
      .clk         (clk),
      .reset       (reset),
      .i_set_stb   (i_set_stb),
      .i_set_addr  (i_set_addr),
      .i_set_data  (i_set_data),
      .i_rb_addr   (i_rb_addr),
      .i_rb_rd_stb (i_rb_rd_stb),
      .i_mod_abs   (i_sfpp1_mod_abs),
      .i_tx_fault  (i_sfpp1_tx_fault),
      .i_rx_los    (i_sfpp1_rx_los),
      .o_status    (sfpp1_status),
      .o_rs        (o_sfpp1_rs)
   );

   //----------------------------------------------------------------------
   // FIFO flag monitor and readback
   //----------------------------------------------------------------------
   fifo_flag_monitor #(
      .CLEAR_ADDR (SR_FIFOFLAGS)
   ) fifo_mon (
      .clk          (clk),
      .reset        (reset),
      .i_set_stb    (i_set_stb),
      .i_set_addr   (i_set_addr),
      .i_set_data   (i_set_data),
      .i_fifo_flags (i_fifo_flags),
      .o_flags      (fifo_flags_word)
   );

   readback_ctrl rb_ctrl (
      .clk               (clk),
      .reset             (reset),
      .i_rb_addr         (i_rb_addr),
      .i_clock_status    (i_clock_status),
      .i_sfpp0_status    (sfpp0_status),
      .i_sfpp1_status    (sfpp1_status),
      .i_fifo_flags_word (fifo_flags_word),
      .o_rb_data         (o_rb_data)
   );

endmodule

/* sim/bus_int_model.svh */
// Cycle model of the register block, stepped once per rising clock edge
// Expects both bus_int packages imported by the including module
`ifndef BUS_INT_MODEL_SVH
`define BUS_INT_MODEL_SVH

// Mirrored control registers
logic [LEDS_W-1:0]         m_leds;
logic [SW_RST_W-1:0]       m_sw_rst;
logic [CLOCK_CTRL_W-1:0]   m_clk_ctrl;
logic [SFPP_RS_W-1:0]      m_rs [2];
// Per cage, pin order ModAbs, TxFault, RxLOS
logic [2:0]                m_sync1 [2];
logic [2:0]                m_sync2 [2];
logic [2:0]                m_chgd [2];
logic [NUM_FIFO_FLAGS-1:0] m_sticky;
// Clear write seen one edge ago
logic                      m_clear_q;
logic [DATA_W-1:0]         m_count;

task automatic model_step(
   input logic                      rst,
   input logic                      stb,
   input logic [SR_AWIDTH-1:0]      addr,
   input logic [DATA_W-1:0]         data,
   input logic [RB_AWIDTH-1:0]      rb_addr,
   input logic                      rd_stb,
   input logic [2:0]                pins0,
   input logic [2:0]                pins1,
   input logic [NUM_FIFO_FLAGS-1:0] flags
);
   logic [2:0]           pins;
   logic [RB_AWIDTH-1:0] st_addr;
   if (rst) begin
      m_leds     = '0;
      m_sw_rst   = '0;
      m_clk_ctrl = 7'h40;
      m_sticky   = '0;
      m_clear_q  = 1'b0;
      m_count    = '0;
      for (int c = 0; c < 2; c++) begin
         m_rs[c]    = '0;
         m_sync1[c] = '0;
         m_sync2[c] = '0;
         m_chgd[c]  = '0;
      end
   end else begin
      if (stb) begin
         case (addr)
            SR_LEDS:       m_leds     = data[LEDS_W-1:0];
            SR_SW_RST:     m_sw_rst   = data[SW_RST_W-1:0];
            SR_CLOCK_CTRL: m_clk_ctrl = data[CLOCK_CTRL_W-1:0];
            SR_SFPP_CTRL0: m_rs[0]    = data[SFPP_RS_W-1:0];
            SR_SFPP_CTRL1: m_rs[1]    = data[SFPP_RS_W-1:0];
            default:       ;
         endcase
      end
      // Clear lands two edges after the strobe and beats a new low flag
      if (m_clear_q) begin
         m_sticky = '0;
      end else begin
         m_sticky = m_sticky | ~flags;
      end
      m_clear_q = stb && (addr == SR_FIFOFLAGS);
      for (int c = 0; c < 2; c++) begin
         pins    = (c == 0) ? pins0 : pins1;
         st_addr = (c == 0) ? RB_SFPP_STATUS0 : RB_SFPP_STATUS1;
         // Strobed read wins over a change in the same cycle
         if (rd_stb && (rb_addr == st_addr)) begin
            m_chgd[c] = '0;
         end else begin
            m_chgd[c] = m_chgd[c] | (m_sync1[c] ^ m_sync2[c]);
         end
         m_sync2[c] = m_sync1[c];
         m_sync1[c] = pins;
      end
      m_count = m_count + 1;
   end
endtask

// Expected readback word for an address, given the current clock status pins
function automatic logic [DATA_W-1:0] model_rb(
   input logic [RB_AWIDTH-1:0]      addr,
   input logic [CLOCK_STATUS_W-1:0] clk_st
);
   logic [DATA_W-1:0] word;
   word = '0;
   case (addr)
      RB_COUNTER:      word = m_count;
      RB_CLK_STATUS:   word[CLOCK_STATUS_W-1:0] = clk_st;
      RB_COMPAT_NUM:   word = {COMPAT_MAJOR, COMPAT_MINOR};
      RB_SFPP_STATUS0: word[5:0] = {m_chgd[0], m_sync2[0]};
      RB_SFPP_STATUS1: word[5:0] = {m_chgd[1], m_sync2[1]};
      RB_FIFOFLAGS:    word[NUM_FIFO_FLAGS-1:0] = m_sticky;
      // Unmapped reads zero
      default:         ;
   endcase
   return word;
endfunction

`endif

/* sim/bus_int_tb.sv */
// Random-stimulus testbench for the board-control register block
// Inputs move 1 ns after the rising edge; outputs are checked at the falling edge
`timescale 1ns/1ps

module bus_int_tb;

   import bus_int_addr_pkg::*;
   import bus_int_board_pkg::*;

   localparam int SEED        = 20688;
   localparam int NUM_WRITES  = 300;
   // Cycles allowed for a pin change to reach its change bit
   localparam int SFP_TIMEOUT = 8;

   logic                      clk;
   logic                      reset;
   logic                      set_stb;
   logic [SR_AWIDTH-1:0]      set_addr;
   logic [DATA_W-1:0]         set_data;
   logic [RB_AWIDTH-1:0]      rb_addr;
   logic                      rb_rd_stb;
   logic [DATA_W-1:0]         rb_data;
   logic [CLOCK_STATUS_W-1:0] clock_status;
   logic [CLOCK_CTRL_W-1:0]   clock_control;
   logic [LEDS_W-1:0]         leds;
   logic [SW_RST_W-1:0]       sw_rst;
   logic [NUM_FIFO_FLAGS-1:0] fifo_flags;
   // ModAbs, TxFault, RxLOS per cage
   logic [2:0]                sfp_pins [2];
   // Board pullups on the open-drain rate-select pins
   tri1  [SFPP_RS_W-1:0]      sfpp0_rs;
   tri1  [SFPP_RS_W-1:0]      sfpp1_rs;

   `include "bus_int_model.svh"

   bus_int_top dut0 (
      .clk              (clk),
      .reset            (reset),
      .i_set_stb        (set_stb),
      .i_set_addr       (set_addr),
      .i_set_data       (set_data),
      .i_rb_addr        (rb_addr),
      .i_rb_rd_stb      (rb_rd_stb),
      .o_rb_data        (rb_data),
      .i_clock_status   (clock_status),
      .o_clock_control  (clock_control),
      .o_leds           (leds),
      .o_sw_rst         (sw_rst),
      .i_fifo_flags     (fifo_flags),
      .i_sfpp0_mod_abs  (sfp_pins[0][2]),
      .i_sfpp0_tx_fault (sfp_pins[0][1]),
      .i_sfpp0_rx_los   (sfp_pins[0][0]),
      .o_sfpp0_rs       (sfpp0_rs),
      .i_sfpp1_mod_abs  (sfp_pins[1][2]),
      .i_sfpp1_tx_fault (sfp_pins[1][1]),
      .i_sfpp1_rx_los   (sfp_pins[1][0]),
      .o_sfpp1_rs       (sfpp1_rs)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Model samples the same inputs the DUT sees at each edge
   always @(posedge clk) begin
      model_step(reset, set_stb, set_addr, set_data, rb_addr, rb_rd_stb,
                 sfp_pins[0], sfp_pins[1], fifo_flags);
   end

   //----------------------------------------------------------------------
   // Check and drive helpers
   //----------------------------------------------------------------------
   task automatic stop_on_error();
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_pins(input string name, input logic [LEDS_W-1:0] exp,
                             input logic [LEDS_W-1:0] act);
      if (act !== exp) begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   // Next drive point; strobes drop unless the caller raises them again
   task automatic next_cycle();
      @(posedge clk);
      #1;
      set_stb   = 1'b0;
      rb_rd_stb = 1'b0;
   endtask

   task automatic read_check(input logic [RB_AWIDTH-1:0] addr, input logic strobe);
      next_cycle();
      rb_addr   = addr;
      rb_rd_stb = strobe;
      @(negedge clk);
      check_word($sformatf("o_rb_data@%0h", addr), model_rb(addr, clock_status), rb_data);
   endtask

   task automatic check_controls();
      logic [SFPP_RS_W-1:0] rs_exp0;
      logic [SFPP_RS_W-1:0] rs_exp1;
      // Set bit pulls low, clear bit floats up to 1
      rs_exp0 = ~m_rs[0];
      rs_exp1 = ~m_rs[1];
      check_pins("o_leds", m_leds, leds);
      check_pins("o_sw_rst", m_sw_rst, sw_rst);
      check_pins("o_clock_control", m_clk_ctrl, clock_control);
      check_pins("o_sfpp0_rs", rs_exp0, sfpp0_rs);
      check_pins("o_sfpp1_rs", rs_exp1, sfpp1_rs);
   endtask

   // Poll a cage until a change bit shows up
   task automatic wait_change(input int cage);
      logic [RB_AWIDTH-1:0] addr;
      logic                 seen;
      int                   n;
      addr = (cage == 0) ? RB_SFPP_STATUS0 : RB_SFPP_STATUS1;
      seen = 1'b0;
      n    = 0;
      while (!seen && n < SFP_TIMEOUT) begin
         read_check(addr, 1'b0);
         seen = (rb_data[5:3] != 3'b000);
         n++;
      end
      if (!seen) begin
         $display("Timeout: change bits of SFP cage %0d were never set", cage);
         stop_on_error();
      end
   endtask

   //----------------------------------------------------------------------
   // Stimulus
   //----------------------------------------------------------------------
   initial begin
      int unsigned       seed_val;
      int unsigned       k;
      int                cage;
      logic [2:0]        mask;
      logic [DATA_W-1:0] c1;
      logic [DATA_W-1:0] c2;
      seed_val     = $urandom(SEED);
      reset        = 1'b1;
      set_stb      = 1'b0;
      set_addr     = '0;
      set_data     = '0;
      rb_addr      = '0;
      rb_rd_stb    = 1'b0;
      clock_status = '0;
      fifo_flags   = '1;
      sfp_pins[0]  = '0;
      sfp_pins[1]  = '0;
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;

      // Reset state
      @(negedge clk);
      check_pins("o_leds", 8'h00, leds);
      check_pins("o_sw_rst", 8'h00, sw_rst);
      check_pins("o_clock_control", 8'h40, clock_control);
      check_pins("o_sfpp0_rs", 8'h03, sfpp0_rs);
      check_pins("o_sfpp1_rs", 8'h03, sfpp1_rs);
      read_check(RB_COMPAT_NUM, 1'b0);
      check_word("compat number", 32'h0008_0000, rb_data);
      read_check(RB_FIFOFLAGS, 1'b0);
      check_word("fifo flags at reset", '0, rb_data);
      read_check(RB_SFPP_STATUS0, 1'b0);
      check_word("sfpp0 status at reset", '0, rb_data);
      read_check(RB_SFPP_STATUS1, 1'b0);
      check_word("sfpp1 status at reset", '0, rb_data);

      // Random settings writes, mapped and unmapped
      for (int i = 0; i < NUM_WRITES; i++) begin
         next_cycle();
         set_stb  = 1'b1;
         set_addr = SR_AWIDTH'($urandom_range(15, 0));
         set_data = $urandom;
         next_cycle();
         @(negedge clk);
         check_controls();
      end

      // Readback decode and counter spacing
      for (int i = 0; i < 50; i++) begin
         next_cycle();
         clock_status = CLOCK_STATUS_W'($urandom);
         rb_addr      = RB_CLK_STATUS;
         @(negedge clk);
         check_word("clock status", model_rb(RB_CLK_STATUS, clock_status), rb_data);
         read_check(RB_AWIDTH'($urandom_range(255, 16)), 1'b0);
         check_word("unmapped readback", '0, rb_data);
         read_check(RB_COUNTER, 1'b0);
         c1 = rb_data;
         k  = $urandom_range(20, 1);
         repeat (k - 1) next_cycle();
         read_check(RB_COUNTER, 1'b0);
         c2 = rb_data;
         check_word("counter delta", k, c2 - c1);
      end

      // SFP change latch and per-cage clear
      for (int i = 0; i < 40; i++) begin
         cage = $urandom_range(1, 0);
         read_check((cage == 0) ? RB_SFPP_STATUS0 : RB_SFPP_STATUS1, 1'b1);
         read_check((cage == 0) ? RB_SFPP_STATUS0 : RB_SFPP_STATUS1, 1'b0);
         check_word("change bits after clear", '0, rb_data & 32'h38);
         next_cycle();
         mask                = 3'($urandom_range(7, 1));
         sfp_pins[cage]      = sfp_pins[cage] ^ mask;
         sfp_pins[1 - cage]  = sfp_pins[1 - cage] ^ 3'($urandom);
         wait_change(cage);
         // Hold the pins while the other cage is read
         repeat (3) read_check((cage == 0) ? RB_SFPP_STATUS1 : RB_SFPP_STATUS0, 1'b0);
      end

      // FIFO sticky flags with occasional clears
      for (int i = 0; i < 80; i++) begin
         next_cycle();
         fifo_flags = ~(NUM_FIFO_FLAGS'($urandom) & NUM_FIFO_FLAGS'($urandom) &
                        NUM_FIFO_FLAGS'($urandom));
         if ($urandom_range(9, 0) == 0) begin
            set_stb  = 1'b1;
            set_addr = SR_FIFOFLAGS;
            set_data = $urandom;
         end
         rb_addr = RB_FIFOFLAGS;
         @(negedge clk);
         check_word("fifo flags", model_rb(RB_FIFOFLAGS, clock_status), rb_data);
      end
      next_cycle();
      fifo_flags = '1;
      set_stb    = 1'b1;
      set_addr   = SR_FIFOFLAGS;
      read_check(RB_FIFOFLAGS, 1'b0);
      read_check(RB_FIFOFLAGS, 1'b0);
      check_word("fifo flags after clear", '0, rb_data);

      $display("test passed");
      $finish;
   end

endmodule

/* bus_int.f */
+incdir+sim
rtl/bus_int_addr_pkg.sv
rtl/bus_int_board_pkg.sv
rtl/setting_reg.sv
rtl/sfpp_port.sv
rtl/fifo_flag_monitor.sv
rtl/readback_ctrl.sv
rtl/bus_int_top.sv
sim/bus_int_tb.sv

/* Bender.yml */
package:
  name: bus_int

sources:
  # Packages first, then leaf modules, then the top level
  - rtl/bus_int_addr_pkg.sv
  - rtl/bus_int_board_pkg.sv
  - rtl/setting_reg.sv
  - rtl/sfpp_port.sv
  - rtl/fifo_flag_monitor.sv
  - rtl/readback_ctrl.sv
  - rtl/bus_int_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/bus_int_tb.sv
